// ==== src/udp_pkg.sv ====
// Shared widths, control codes, header/word types and the last-word test

package udp_pkg;

   // ----------------------------------------------------------------------
   // Widths
   // ----------------------------------------------------------------------
   localparam int DATA_WIDTH  = 64;
   localparam int CTRL_WIDTH  = 8;
   localparam int NUM_PORTS   = 4;
   localparam int PORT_BITS   = 2;
   localparam int FIELD_WIDTH = 16;

   // ----------------------------------------------------------------------
   // Control codes
   // ----------------------------------------------------------------------
   // All ones tags the module header
   localparam logic [CTRL_WIDTH-1:0] CTRL_IO_HDR = {CTRL_WIDTH{1'b1}};
   // Zero tags a payload word, anything else ends the packet
   localparam logic [CTRL_WIDTH-1:0] CTRL_DATA   = {CTRL_WIDTH{1'b0}};

   // ----------------------------------------------------------------------
   // Word types
   // ----------------------------------------------------------------------
   // Module header, fields listed from the top bit down
   typedef struct packed {
      logic [FIELD_WIDTH-1:0] dst_port;   // one-hot
      logic [FIELD_WIDTH-1:0] word_len;
      logic [FIELD_WIDTH-1:0] src_port;   // binary
      logic [FIELD_WIDTH-1:0] byte_len;
   } io_header_t;

   // Same 64 bits, read as header or as payload depending on ctrl
   typedef union packed {
      logic [DATA_WIDTH-1:0] raw;
      io_header_t            hdr;
   } pkt_data_u;

   // One word on a stream channel
   typedef struct packed {
      pkt_data_u             data;
      logic [CTRL_WIDTH-1:0] ctrl;
   } stream_word_t;

   // True for the closing word of a packet
   function automatic logic is_last_word(input logic [CTRL_WIDTH-1:0] ctrl);
      return (ctrl != CTRL_IO_HDR) && (ctrl != CTRL_DATA);
   endfunction

endpackage

// ==== src/input_arbiter.sv ====
// Packet-granular round-robin arbiter over four input ports with one output register
`timescale 1ns/1ps

module input_arbiter (
   input  logic                           clk,
   input  logic                           arst_n,

   input  udp_pkg::stream_word_t          in_word [udp_pkg::NUM_PORTS],
   input  logic [udp_pkg::NUM_PORTS-1:0]  in_valid,
   output logic [udp_pkg::NUM_PORTS-1:0]  in_ready,

   output udp_pkg::stream_word_t          out_word,
   output logic                           out_valid,
   input  logic                           out_ready
);

   import udp_pkg::*;

   logic                 busy_q;
   logic [NUM_PORTS-1:0] grant_q;
   logic [PORT_BITS-1:0] last_q;

   logic                 found;
   logic [PORT_BITS-1:0] next_port;
   logic [PORT_BITS-1:0] idx;

   stream_word_t         sel_word;
   logic                 load;
   logic                 take;

   // ----------------------------------------------------------------------
   // Round-robin search, starting at the port after the last grant
   // ----------------------------------------------------------------------
   always_comb begin
      found     = 1'b0;
      next_port = last_q;
      idx       = last_q;
      for (int i = 1; i <= NUM_PORTS; i++) begin
         idx = last_q + PORT_BITS'(i);
         if (!found && in_valid[idx]) begin
            found     = 1'b1;
            next_port = idx;
         end
      end
   end

   // Word from the granted port
   always_comb begin
      sel_word = in_word[0];
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (grant_q[p]) begin
            sel_word = in_word[p];
         end
      end
   end

   // Register can take a word when empty or draining this cycle
   assign load     = !out_valid || out_ready;
   assign in_ready = (busy_q && load) ? grant_q : '0;
   assign take     = |(in_valid & in_ready);

   // ----------------------------------------------------------------------
   // Grant state
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q  <= 1'b0;
         grant_q <= '0;
         last_q  <= PORT_BITS'(NUM_PORTS - 1);
      end else if (!busy_q) begin
         if (found) begin
            busy_q  <= 1'b1;
            grant_q <= NUM_PORTS'(1) << next_port;
            last_q  <= next_port;
         end
      end else if (take && is_last_word(sel_word.ctrl)) begin
         // Packet done, back to searching
         busy_q  <= 1'b0;
         grant_q <= '0;
      end
   end

   // ----------------------------------------------------------------------
   // Output register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= take;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_word <= sel_word;
      end
   end

endmodule

// ==== src/output_port_lookup.sv ====
// Output port lookup stage that rewrites dst_port in each module header
`timescale 1ns/1ps

module output_port_lookup (
   input  logic                  clk,
   input  logic                  arst_n,

   input  udp_pkg::stream_word_t in_word,
   input  logic                  in_valid,
   output logic                  in_ready,

   output udp_pkg::stream_word_t out_word,
   output logic                  out_valid,
   input  logic                  out_ready
);

   import udp_pkg::*;

   logic [PORT_BITS-1:0] dst_idx;
   io_header_t           in_hdr;
   stream_word_t         lut_word;
   logic                 take;

   // I/O port pairs with the next CPU port and back again
   assign dst_idx = in_word.data.hdr.src_port[PORT_BITS-1:0] ^ PORT_BITS'(1);

   // ----------------------------------------------------------------------
   // Header rewrite
   // ----------------------------------------------------------------------
   always_comb begin
      in_hdr        = in_word.data.hdr;
      lut_word.ctrl = in_word.ctrl;
      if (in_word.ctrl == CTRL_IO_HDR) begin
         in_hdr.dst_port   = FIELD_WIDTH'(1) << dst_idx;
         lut_word.data.hdr = in_hdr;
      end else begin
         // Payload and last words pass as they are
         lut_word.data.raw = in_word.data.raw;
      end
   end

   assign in_ready = !out_valid || out_ready;
   assign take     = in_valid && in_ready;

   // ----------------------------------------------------------------------
   // Stage register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_word <= lut_word;
      end
   end

endmodule

// ==== src/output_demux.sv ====
// Output demultiplexer that steers whole packets to the port in their header
`timescale 1ns/1ps

module output_demux (
   input  logic                           clk,
   input  logic                           arst_n,

   input  udp_pkg::stream_word_t          in_word,
   input  logic                           in_valid,
   output logic                           in_ready,

   output udp_pkg::stream_word_t          out_word [udp_pkg::NUM_PORTS],
   output logic [udp_pkg::NUM_PORTS-1:0]  out_valid,
   input  logic [udp_pkg::NUM_PORTS-1:0]  out_ready
);

   import udp_pkg::*;

   stream_word_t         word_q;
   logic                 valid_q;
   logic [NUM_PORTS-1:0] sel_q;

   logic                 sel_ready;
   logic                 leave;
   logic                 take;

   // Ready comes only from the selected port
   assign sel_ready = |(out_ready & sel_q);
   assign leave     = valid_q && sel_ready;
   assign in_ready  = !valid_q || sel_ready;
   assign take      = in_valid && in_ready;

   // ----------------------------------------------------------------------
   // Word register and port select
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
         sel_q   <= '0;
      end else begin
         if (in_ready) begin
            valid_q <= in_valid;
         end
         // A new header wins over the release of the previous packet
         if (take && in_word.ctrl == CTRL_IO_HDR) begin
            sel_q <= in_word.data.hdr.dst_port[NUM_PORTS-1:0];
         end else if (leave && is_last_word(word_q.ctrl)) begin
            sel_q <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         word_q <= in_word;
      end
   end

   // ----------------------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------------------
   assign out_valid = {NUM_PORTS{valid_q}} & sel_q;

   // Same word on every port, valid picks the one that takes it
   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         out_word[p] = word_q;
      end
   end

endmodule

// ==== src/user_data_path.sv ====
// Top level of the user data path, chaining arbiter, port lookup and demux
`timescale 1ns/1ps

// Ports 0 and 2 face the I/O side, ports 1 and 3 are their CPU partners
module user_data_path (
   input  logic                           clk,
   input  logic                           arst_n,

   input  udp_pkg::stream_word_t          in_word [udp_pkg::NUM_PORTS],
   input  logic [udp_pkg::NUM_PORTS-1:0]  in_valid,
   output logic [udp_pkg::NUM_PORTS-1:0]  in_ready,

   output udp_pkg::stream_word_t          out_word [udp_pkg::NUM_PORTS],
   output logic [udp_pkg::NUM_PORTS-1:0]  out_valid,
   input  logic [udp_pkg::NUM_PORTS-1:0]  out_ready
);

   import udp_pkg::*;

   // ----------------------------------------------------------------------
   // Stage links
   // ----------------------------------------------------------------------
   stream_word_t arb_word;
   logic         arb_valid;
   logic         arb_ready;

   stream_word_t lut_word;
   logic         lut_valid;
   logic         lut_ready;

   input_arbiter input_arbiter (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_word    (in_word),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .out_word   (arb_word),
      .out_valid  (arb_valid),
      .out_ready  (arb_ready)
   );

   output_port_lookup output_port_lookup (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_word    (arb_word),
      .in_valid   (arb_valid),
      .in_ready   (arb_ready),
      .out_word   (lut_word),
      .out_valid  (lut_valid),
      .out_ready  (lut_ready)
   );

   output_demux output_demux (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_word    (lut_word),
      .in_valid   (lut_valid),
      .in_ready   (lut_ready),
      .out_word   (out_word),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

// ==== sim/user_data_path_sva.sv ====
// Concurrent assertions on output handshake, output exclusivity and reset behavior
`timescale 1ns/1ps

module user_data_path_sva (
   input logic                          clk,
   input logic                          arst_n,
   input logic [udp_pkg::NUM_PORTS-1:0] in_ready,
   input udp_pkg::stream_word_t         out_word [udp_pkg::NUM_PORTS],
   input logic [udp_pkg::NUM_PORTS-1:0] out_valid,
   input logic [udp_pkg::NUM_PORTS-1:0] out_ready
);

   import udp_pkg::*;

   // A stalled output keeps its word until it is taken
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
         out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_word[p]))
         else $error("Output %0d dropped or changed its word while stalled", p);
   end

   one_output: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(out_valid))
      else $error("More than one out_valid high: %b", out_valid);

   quiet_in_reset: assert property (@(posedge clk)
      !arst_n |-> in_ready == '0)
      else $error("in_ready high during reset: %b", in_ready);

endmodule

// ==== sim/tb_user_data_path.sv ====
// Testbench for the user data path with random packets, a scoreboard model and a result line
`timescale 1ns/1ps

module tb_user_data_path;

   import udp_pkg::*;

   localparam int          PKTS_RANDOM = 20;
   localparam int          PKTS_RR     = 4;
   localparam int          MIN_WORDS   = 1;
   localparam int          MAX_WORDS   = 6;
   localparam int          TIMEOUT     = 2000;
   localparam logic [31:0] SEED        = 32'hdb3b_553f;

   logic                 clk = 1'b0;
   logic                 arst_n;
   stream_word_t         in_word [NUM_PORTS];
   logic [NUM_PORTS-1:0] in_valid;
   logic [NUM_PORTS-1:0] in_ready;
   stream_word_t         out_word [NUM_PORTS];
   logic [NUM_PORTS-1:0] out_valid;
   logic [NUM_PORTS-1:0] out_ready;

   // Expected words per output port
   stream_word_t         exp_q [NUM_PORTS][$];

   int                   mon_errors = 0;
   int                   seq_errors = 0;
   logic                 rr_on      = 1'b0;
   logic                 have_prev  = 1'b0;
   logic [PORT_BITS-1:0] prev_src;

   user_data_path uut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_word   (in_word),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_word  (out_word),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   bind user_data_path user_data_path_sva sva (.*);

   always #5 clk = ~clk;

   // Random back-pressure on every output
   always @(negedge clk) begin
      out_ready = NUM_PORTS'($urandom);
   end

   function automatic int pending_words();
      int n;
      n = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         n += exp_q[p].size();
      end
      return n;
   endfunction

   // I/O ports 0 and 2 pair with CPU ports 1 and 3
   function automatic int partner_port(input int port);
      case (port)
         0:       return 1;
         1:       return 0;
         2:       return 3;
         default: return 2;
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   // Runs from a falling edge to the falling edge after acceptance
   task automatic send_word(input int port, input stream_word_t w, output bit ok);
      int waited;
      in_word[port]  = w;
      in_valid[port] = 1'b1;
      waited = 0;
      ok     = 1'b0;
      while (!ok && waited < TIMEOUT) begin
         @(posedge clk);
         ok = in_ready[port];
         waited++;
      end
      @(negedge clk);
      if (!ok) begin
         seq_errors++;
         $display("Timeout at %0t: input port %0d never saw in_ready", $time, port);
         in_valid[port] = 1'b0;
      end
   endtask

   task automatic send_packets(input int port, input int count, input bit gaps);
      stream_word_t w;
      stream_word_t exp_w;
      int           n;
      int           k;
      int           dst;
      bit           ok;
      dst = partner_port(port);
      for (int i = 0; i < count; i++) begin
         n = $urandom_range(MAX_WORDS, MIN_WORDS);
         k = $urandom_range(7, 0);
         w.ctrl                = CTRL_IO_HDR;
         w.data.hdr.dst_port   = 16'($urandom);
         w.data.hdr.word_len   = 16'(n);
         w.data.hdr.src_port   = 16'(port);
         w.data.hdr.byte_len   = 16'((n - 1) * 8 + 8 - k);
         exp_w                 = w;
         exp_w.data.hdr.dst_port = 16'(1) << dst;
         exp_q[dst].push_back(exp_w);
         send_word(port, w, ok);
         if (!ok) return;
         for (int j = 1; j <= n; j++) begin
            w.data.raw = {$urandom, $urandom};
            w.ctrl     = (j == n) ? 8'(1) << k : CTRL_DATA;
            exp_q[dst].push_back(w);
            send_word(port, w, ok);
            if (!ok) return;
         end
         if (gaps && $urandom_range(1, 0) == 1) begin
            in_valid[port] = 1'b0;
            repeat ($urandom_range(3, 1)) @(negedge clk);
         end
      end
      in_valid[port] = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (pending_words() != 0 && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (pending_words() == 0) else begin
         seq_errors++;
         $display("Timeout at %0t: %0d words never left the DUT", $time, pending_words());
      end
   endtask

   // ----------------------------------------------------------------------
   // Output monitor and scoreboard
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      stream_word_t         exp_w;
      logic [PORT_BITS-1:0] src;
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (arst_n && out_valid[p] && out_ready[p]) begin
            assert (exp_q[p].size() != 0) else begin
               mon_errors++;
               $display("Unexpected word on output %0d at %0t with nothing pending", p, $time);
            end
            if (exp_q[p].size() != 0) begin
               exp_w = exp_q[p].pop_front();
               assert (out_word[p] == exp_w) else begin
                  mon_errors++;
                  $display("Mismatch at %0t: out_word[%0d] = %h, expected %h",
                           $time, p, out_word[p], exp_w);
               end
            end
            // Headers leave in round-robin source order while all inputs wait
            if (rr_on && out_word[p].ctrl == CTRL_IO_HDR) begin
               src = out_word[p].data.hdr.src_port[PORT_BITS-1:0];
               if (have_prev) begin
                  assert (src == PORT_BITS'(prev_src + 1)) else begin
                     mon_errors++;
                     $display("Mismatch at %0t: src_port = %0d, expected %0d",
                              $time, src, PORT_BITS'(prev_src + 1));
                  end
               end
               prev_src  = src;
               have_prev = 1'b1;
            end
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      arst_n    = 1'b0;
      in_valid  = '0;
      out_ready = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_word[p] = '0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      assert (out_valid == '0 && in_ready == '0) else begin
         seq_errors++;
         $display("Mismatch at %0t: out_valid = %b, in_ready = %b, expected 0000 after reset",
                  $time, out_valid, in_ready);
      end

      fork
         send_packets(0, PKTS_RANDOM, 1'b1);
         send_packets(1, PKTS_RANDOM, 1'b1);
         send_packets(2, PKTS_RANDOM, 1'b1);
         send_packets(3, PKTS_RANDOM, 1'b1);
      join
      wait_drain();

      // All four inputs saturated from the same edge on
      rr_on = 1'b1;
      fork
         send_packets(0, PKTS_RR, 1'b0);
         send_packets(1, PKTS_RR, 1'b0);
         send_packets(2, PKTS_RR, 1'b0);
         send_packets(3, PKTS_RR, 1'b0);
      join
      wait_drain();

      $display("Errors: %0d output check(s), %0d sequence check(s)", mon_errors, seq_errors);
      if (mon_errors == 0 && seq_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
src/udp_pkg.sv
src/input_arbiter.sv
src/output_port_lookup.sv
src/output_demux.sv
src/user_data_path.sv
sim/user_data_path_sva.sv
sim/tb_user_data_path.sv

// ==== Makefile ====
# Verilator build and run of the user data path testbench

VERILATOR ?= verilator
TOP       ?= tb_user_data_path
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@! grep -q "TEST RESULT: FAIL" $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
